// File: include/x86_exec_macros.svh
`ifndef X86_EXEC_MACROS_SVH
`define X86_EXEC_MACROS_SVH

// Architectural data width
`define X86_WORD_W 32

// EFLAGS bit positions
`define X86_EFLAGS_CF 0
`define X86_EFLAGS_PF 2
`define X86_EFLAGS_AF 4
`define X86_EFLAGS_ZF 6
`define X86_EFLAGS_SF 7
`define X86_EFLAGS_DF 10
`define X86_EFLAGS_OF 11

// First fetch address out of reset
`define X86_RESET_EIP 32'h0000_1000

// Reserved bit 1 always reads as one
`define X86_RESET_EFLAGS 32'h0000_0002

`endif

// File: hw/x86_exec_pkg.sv
`include "x86_exec_macros.svh"

package x86_exec_pkg;

  // Plain vectors with a meaning
  typedef logic [`X86_WORD_W-1:0] word_t;
  typedef logic [`X86_WORD_W-1:0] eflags_t;
  typedef logic [3:0]             ilen_t;

  // One value per supported command
  typedef enum logic [6:0] {
    cmd_nop,
    // ALU
    cmd_add, cmd_adc, cmd_inc, cmd_sub, cmd_sbb, cmd_dec, cmd_cmp,
    cmd_and, cmd_test, cmd_or, cmd_xor, cmd_not,
    cmd_shl, cmd_shr, cmd_rol, cmd_ror,
    // Stack and ECX adjusts
    cmd_push, cmd_pop, cmd_callr, cmd_calli, cmd_ret,
    cmd_loop, cmd_loope, cmd_loopne,
    // Moves
    cmd_mov, cmd_lea, cmd_movsx, cmd_movzx, cmd_xchg,
    // Flag manipulation
    cmd_stc, cmd_clc, cmd_std, cmd_cld, cmd_lahf, cmd_sahf,
    // Branches
    cmd_jmp, cmd_jz, cmd_jnz, cmd_jecxz
  } cmd_e;

  // Condensed view of the arithmetic flags plus DF
  typedef struct packed {
    logic df;
    logic af;
    logic cf;
    logic pf;
    logic zf;
    logic sf;
    logic of;
  } status_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_shl, alu_shr, alu_rol, alu_ror, alu_none
  } alu_op_e;

  typedef struct packed {
    alu_op_e op;
    logic    src_inv;     // Invert second operand
    logic    use_carry;   // Fold CF into the adder
    logic    keep_cf;     // INC and DEC leave CF alone
    logic    no_flags;    // Result only
    logic    clear_cf_of; // Logic ops clear CF, OF and AF
  } alu_cntl_t;

  // Decoded instruction
  typedef struct packed {
    cmd_e  opc;
    word_t opnd0;
    word_t opnd1;
    word_t opnd2;
    ilen_t instr_len;
    logic  ecx_is_zero;
  } exec_req_t;

  // Write-back bundle
  typedef struct packed {
    word_t   opnd0_w;
    word_t   opnd1_w;
    eflags_t eflags;
    word_t   next_eip;
  } exec_res_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/100ps
`include "x86_exec_macros.svh"

module alu (
  input  x86_exec_pkg::alu_cntl_t cntl,
  input  x86_exec_pkg::status_t   status_in,
  input  x86_exec_pkg::word_t     opnd0,
  input  x86_exec_pkg::word_t     opnd1,
  output x86_exec_pkg::word_t     result,
  output x86_exec_pkg::status_t   status_out
);
  import x86_exec_pkg::*;

  word_t                opnd_b;
  logic                 is_sub;
  logic                 carry_in;
  logic [`X86_WORD_W:0] sum;
  logic                 carry4;
  logic [4:0]           shamt;
  logic [5:0]           shamt_inv;
  logic [`X86_WORD_W:0] shl_ext;
  logic [`X86_WORD_W:0] shr_ext;
  word_t                rol_res;
  word_t                ror_res;
  logic                 res_zf;
  logic                 res_sf;
  logic                 res_pf;

  assign is_sub = (cntl.op == alu_sub);
  assign opnd_b = cntl.src_inv ? ~opnd1 : opnd1;

  // Subtract is a + ~b + 1, SBB drops the +1 when CF is set
  assign carry_in = is_sub ? ~(cntl.use_carry & status_in.cf)
                           : (cntl.use_carry & status_in.cf);

  assign sum = {1'b0, opnd0} + {1'b0, opnd_b} + {{`X86_WORD_W{1'b0}}, carry_in};

  // Carry into bit 4
  assign carry4 = opnd0[4] ^ opnd_b[4] ^ sum[4];

  // Shift count is five bits wide
  assign shamt     = opnd1[4:0];
  assign shamt_inv = 6'd32 - {1'b0, shamt};

  // Extra bit catches the last bit shifted out
  assign shl_ext = {1'b0, opnd0} << shamt;
  assign shr_ext = {opnd0, 1'b0} >> shamt;
  assign rol_res = (opnd0 << shamt) | (opnd0 >> shamt_inv);
  assign ror_res = (opnd0 >> shamt) | (opnd0 << shamt_inv);

  always_comb begin
    case (cntl.op)
      alu_add, alu_sub: result = sum[`X86_WORD_W-1:0];
      alu_and:          result = opnd0 & opnd_b;
      alu_or:           result = opnd0 | opnd_b;
      alu_xor:          result = opnd0 ^ opnd_b;
      alu_shl:          result = shl_ext[`X86_WORD_W-1:0];
      alu_shr:          result = shr_ext[`X86_WORD_W:1];
      alu_rol:          result = rol_res;
      alu_ror:          result = ror_res;
      default:          result = opnd0;
    endcase
  end

  // Result-derived flags, PF looks at the low byte only
  assign res_zf = (result == '0);
  assign res_sf = result[`X86_WORD_W-1];
  assign res_pf = ~^result[7:0];

  always_comb begin
    status_out = status_in;
    if (!cntl.no_flags) begin
      case (cntl.op)
        alu_add, alu_sub: begin
          // CF is a borrow for subtract
          status_out.cf = cntl.keep_cf ? status_in.cf : (is_sub ? ~sum[`X86_WORD_W] : sum[`X86_WORD_W]);
          status_out.af = is_sub ? ~carry4 : carry4;
          // Same sign in, different sign out
          status_out.of = (opnd0[`X86_WORD_W-1] == opnd_b[`X86_WORD_W-1]) &
                          (result[`X86_WORD_W-1] ^ opnd0[`X86_WORD_W-1]);
          status_out.zf = res_zf;
          status_out.sf = res_sf;
          status_out.pf = res_pf;
        end
        alu_and, alu_or, alu_xor: begin
          status_out.zf = res_zf;
          status_out.sf = res_sf;
          status_out.pf = res_pf;
          if (cntl.clear_cf_of) begin
            status_out.cf = 1'b0;
            status_out.of = 1'b0;
            status_out.af = 1'b0;
          end
        end
        alu_shl, alu_shr: begin
          // Zero count leaves flags alone, OF and AF kept
          if (shamt != '0) begin
            status_out.cf = (cntl.op == alu_shl) ? shl_ext[`X86_WORD_W] : shr_ext[0];
            status_out.zf = res_zf;
            status_out.sf = res_sf;
            status_out.pf = res_pf;
          end
        end
        alu_rol: begin
          if (shamt != '0) status_out.cf = rol_res[0];
        end
        alu_ror: begin
          if (shamt != '0) status_out.cf = ror_res[`X86_WORD_W-1];
        end
        default: ;
      endcase
    end
  end

endmodule

// File: hw/meta_unit.sv
`timescale 1ns/100ps

module meta_unit (
  input  x86_exec_pkg::cmd_e    opc,
  input  x86_exec_pkg::word_t   opnd,
  input  x86_exec_pkg::status_t status_in,
  output x86_exec_pkg::status_t status_out,
  output x86_exec_pkg::word_t   ah_result
);
  import x86_exec_pkg::*;

  // AH image is SF ZF 0 AF 0 PF 1 CF
  assign ah_result = {opnd[31:16],
                      status_in.sf, status_in.zf, 1'b0, status_in.af,
                      1'b0, status_in.pf, 1'b1, status_in.cf,
                      opnd[7:0]};

  always_comb begin
    status_out = status_in;
    case (opc)
      cmd_stc: status_out.cf = 1'b1;
      cmd_clc: status_out.cf = 1'b0;
      cmd_std: status_out.df = 1'b1;
      cmd_cld: status_out.df = 1'b0;
      cmd_sahf: begin
        // OF and DF are outside AH
        status_out.sf = opnd[15];
        status_out.zf = opnd[14];
        status_out.af = opnd[12];
        status_out.pf = opnd[10];
        status_out.cf = opnd[8];
      end
      // LAHF only reads flags
      default: ;
    endcase
  end

endmodule

// File: hw/cfu.sv
`timescale 1ns/100ps
`include "x86_exec_macros.svh"

module cfu (
  input  x86_exec_pkg::cmd_e    opc,
  input  x86_exec_pkg::eflags_t eflags,
  input  x86_exec_pkg::word_t   eip,
  input  x86_exec_pkg::ilen_t   instr_len,
  input  x86_exec_pkg::word_t   target,
  input  logic                  ecx_is_zero,
  output x86_exec_pkg::word_t   next_eip
);
  import x86_exec_pkg::*;

  logic  zf;
  logic  taken;
  word_t fall_through;

  assign zf = eflags[`X86_EFLAGS_ZF];

  always_comb begin
    case (opc)
      // Unconditional transfers
      cmd_jmp, cmd_callr, cmd_calli, cmd_ret: taken = 1'b1;
      cmd_jz:     taken = zf;
      cmd_jnz:    taken = ~zf;
      cmd_jecxz:  taken = ecx_is_zero;
      // ECX already decremented here
      cmd_loop:   taken = ~ecx_is_zero;
      cmd_loope:  taken = ~ecx_is_zero & zf;
      cmd_loopne: taken = ~ecx_is_zero & ~zf;
      default:    taken = 1'b0;
    endcase
  end

  // Sequential path skips the current instruction
  assign fall_through = eip + word_t'(instr_len);

  assign next_eip = taken ? target : fall_through;

endmodule

// File: hw/execute.sv
`timescale 1ns/100ps
`include "x86_exec_macros.svh"

module execute (
  input  x86_exec_pkg::exec_req_t req,
  input  x86_exec_pkg::eflags_t   eflags,
  input  x86_exec_pkg::word_t     eip,
  output x86_exec_pkg::exec_res_t next_res
);
  import x86_exec_pkg::*;

  alu_cntl_t cntl;
  status_t   cur_status;
  status_t   alu_status;
  status_t   meta_status;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  word_t     ah_word;
  word_t     cfu_eip;
  logic      is_loop;
  logic      is_adjust;
  logic      is_alu;
  logic      is_move;
  logic      is_meta;
  logic      no_wr;
  logic      ecx_zero_eff;

  // Overlay a status vector on the current EFLAGS
  function automatic eflags_t merge_status(eflags_t base, status_t st);
    eflags_t f;
    f = base;
    f[`X86_EFLAGS_CF] = st.cf;
    f[`X86_EFLAGS_PF] = st.pf;
    f[`X86_EFLAGS_AF] = st.af;
    f[`X86_EFLAGS_ZF] = st.zf;
    f[`X86_EFLAGS_SF] = st.sf;
    f[`X86_EFLAGS_DF] = st.df;
    f[`X86_EFLAGS_OF] = st.of;
    return f;
  endfunction

  assign cur_status = '{df: eflags[`X86_EFLAGS_DF], af: eflags[`X86_EFLAGS_AF],
                        cf: eflags[`X86_EFLAGS_CF], pf: eflags[`X86_EFLAGS_PF],
                        zf: eflags[`X86_EFLAGS_ZF], sf: eflags[`X86_EFLAGS_SF],
                        of: eflags[`X86_EFLAGS_OF]};

  // Command classes
  assign is_loop   = req.opc inside {cmd_loop, cmd_loope, cmd_loopne};
  assign is_adjust = is_loop || (req.opc inside {cmd_push, cmd_pop, cmd_callr, cmd_calli,
                                                 cmd_ret});
  assign is_move   = req.opc inside {cmd_mov, cmd_lea, cmd_movsx, cmd_movzx, cmd_xchg};
  assign is_meta   = req.opc inside {cmd_stc, cmd_clc, cmd_std, cmd_cld, cmd_lahf, cmd_sahf};
  // CMP and TEST only leave flags behind
  assign no_wr     = req.opc inside {cmd_cmp, cmd_test};

  always_comb begin
    case (req.opc)
      cmd_add, cmd_adc, cmd_inc, cmd_pop, cmd_ret: cntl.op = alu_add;
      cmd_sub, cmd_sbb, cmd_dec, cmd_cmp,
      cmd_push, cmd_callr, cmd_calli,
      cmd_loop, cmd_loope, cmd_loopne:             cntl.op = alu_sub;
      cmd_and, cmd_test:                           cntl.op = alu_and;
      cmd_or:                                      cntl.op = alu_or;
      cmd_xor, cmd_not:                            cntl.op = alu_xor;
      cmd_shl:                                     cntl.op = alu_shl;
      cmd_shr:                                     cntl.op = alu_shr;
      cmd_rol:                                     cntl.op = alu_rol;
      cmd_ror:                                     cntl.op = alu_ror;
      default:                                     cntl.op = alu_none;
    endcase
    // NOT is XOR against an inverted zero
    cntl.src_inv     = (cntl.op == alu_sub) || (req.opc == cmd_not);
    cntl.use_carry   = req.opc inside {cmd_adc, cmd_sbb};
    cntl.keep_cf     = req.opc inside {cmd_inc, cmd_dec};
    cntl.no_flags    = is_adjust || (req.opc == cmd_not);
    cntl.clear_cf_of = req.opc inside {cmd_and, cmd_test, cmd_or, cmd_xor};
  end

  // Adjusts run inside the ALU but are not ALU results
  assign is_alu = (cntl.op != alu_none) && !is_adjust;

  // Adjusts shift the operands down, ESP or ECX in opnd1 and the step in opnd2
  always_comb begin
    alu_a = is_adjust ? req.opnd1 : req.opnd0;
    if (is_adjust)           alu_b = req.opnd2;
    else if (cntl.keep_cf)   alu_b = word_t'(1);
    else if (req.opc == cmd_not) alu_b = '0;
    else                     alu_b = req.opnd1;
  end

  alu alu_i (
    .cntl       (cntl),
    .status_in  (cur_status),
    .opnd0      (alu_a),
    .opnd1      (alu_b),
    .result     (alu_result),
    .status_out (alu_status)
  );

  meta_unit meta_unit_i (
    .opc        (req.opc),
    .opnd       (req.opnd0),
    .status_in  (cur_status),
    .status_out (meta_status),
    .ah_result  (ah_word)
  );

  // LOOPcc tests the decremented ECX
  assign ecx_zero_eff = is_loop ? (alu_result == '0) : req.ecx_is_zero;

  cfu cfu_i (
    .opc         (req.opc),
    .eflags      (eflags),
    .eip         (eip),
    .instr_len   (req.instr_len),
    .target      (req.opnd0),
    .ecx_is_zero (ecx_zero_eff),
    .next_eip    (cfu_eip)
  );

  always_comb begin
    // First write operand
    if (is_alu && !no_wr) begin
      next_res.opnd0_w = alu_result;
    end else if (is_move) begin
      case (req.opc)
        cmd_movsx: next_res.opnd0_w = {{24{req.opnd1[7]}}, req.opnd1[7:0]};
        cmd_movzx: next_res.opnd0_w = {24'b0, req.opnd1[7:0]};
        // MOV, LEA and XCHG all take opnd1
        default:   next_res.opnd0_w = req.opnd1;
      endcase
    end else if (req.opc == cmd_lahf) begin
      next_res.opnd0_w = ah_word;
    end else begin
      next_res.opnd0_w = req.opnd0;
    end

    // Second write operand, ESP or ECX for adjusts
    if (is_adjust)                next_res.opnd1_w = alu_result;
    else if (req.opc == cmd_xchg) next_res.opnd1_w = req.opnd0;
    else                          next_res.opnd1_w = req.opnd1;

    // Only ALU and meta unit touch flags
    if (is_alu)       next_res.eflags = merge_status(eflags, alu_status);
    else if (is_meta) next_res.eflags = merge_status(eflags, meta_status);
    else              next_res.eflags = eflags;

    next_res.next_eip = cfu_eip;
  end

endmodule

// File: hw/arch_state.sv
`timescale 1ns/100ps
`include "x86_exec_macros.svh"

module arch_state (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    instr_valid,
  input  x86_exec_pkg::exec_res_t next_res,
  output x86_exec_pkg::eflags_t   eflags,
  output x86_exec_pkg::word_t     eip,
  output logic                    res_valid,
  output x86_exec_pkg::exec_res_t res
);

  // One-cycle pulse after each strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= instr_valid;
    end
  end

  // Architectural EFLAGS and EIP feed the next instruction
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      eflags <= `X86_RESET_EFLAGS;
      eip    <= `X86_RESET_EIP;
    end else if (instr_valid) begin
      eflags <= next_res.eflags;
      eip    <= next_res.next_eip;
    end
  end

  // Result register, held between strobes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res <= '0;
    end else if (instr_valid) begin
      res <= next_res;
    end
  end

endmodule

// File: hw/x86_exec_top.sv
`timescale 1ns/100ps

module x86_exec_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    instr_valid,
  input  x86_exec_pkg::exec_req_t req,
  output logic                    res_valid,
  output x86_exec_pkg::exec_res_t res,
  output x86_exec_pkg::eflags_t   eflags,
  output x86_exec_pkg::word_t     eip
);
  import x86_exec_pkg::*;

  eflags_t   cur_eflags;
  word_t     cur_eip;
  exec_res_t next_res;

  arch_state arch_state_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .next_res    (next_res),
    .eflags      (cur_eflags),
    .eip         (cur_eip),
    .res_valid   (res_valid),
    .res         (res)
  );

  // Committed state closes the loop through execute
  execute execute_i (
    .req      (req),
    .eflags   (cur_eflags),
    .eip      (cur_eip),
    .next_res (next_res)
  );

  assign eflags = cur_eflags;
  assign eip    = cur_eip;

endmodule

// File: tests/x86_exec_tb.sv
`timescale 1ns/100ps
`include "x86_exec_macros.svh"

module x86_exec_tb;
  import x86_exec_pkg::*;

  // Instruction counts per test
  localparam int N_ALU  = 300;
  localparam int N_ADJ  = 120;
  localparam int N_MOVE = 80;
  localparam int N_META = 120;
  localparam int N_BR   = 100;
  localparam int N_ALL  = N_ALU + N_ADJ + N_MOVE + N_META + N_BR;
  // At most one idle cycle after each strobe
  localparam int CYCLE_LIMIT = 2 * N_ALL + 100;

  logic      clk;
  logic      arst_n;
  logic      instr_valid;
  exec_req_t req;
  logic      res_valid;
  exec_res_t res;
  eflags_t   eflags;
  word_t     eip;

  // Reference copy of the architectural state
  eflags_t m_eflags;
  word_t   m_eip;

  int cycle_cnt = 0;
  int err_cnt = 0;
  int check_cnt = 0;
  int test_err_base = 0;

  x86_exec_top x86_exec_top_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .req         (req),
    .res_valid   (res_valid),
    .res         (res),
    .eflags      (eflags),
    .eip         (eip)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt++;

  // Watchdog
  initial begin
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_eflags(input string what, input eflags_t got, input eflags_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_valid(input string what, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s done, %0d errors", name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // Set when the low byte has an even number of ones
  function automatic logic even_parity(input logic [7:0] b);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++) ones += b[i];
    return (ones % 2) == 0;
  endfunction

  function automatic eflags_t with_szp(input eflags_t f, input word_t r);
    eflags_t g;
    g = f;
    g[`X86_EFLAGS_ZF] = (r == 0);
    g[`X86_EFLAGS_SF] = r[31];
    g[`X86_EFLAGS_PF] = even_parity(r[7:0]);
    return g;
  endfunction

  // Add or subtract with optional carry in
  task automatic arith(input word_t a, input word_t b, input logic cin, input logic sub,
                       input logic keep_cf, inout eflags_t f, output word_t r);
    logic [32:0] wide;
    if (sub) begin
      wide = {1'b0, a} - {1'b0, b} - {32'b0, cin};
      r = wide[31:0];
      f[`X86_EFLAGS_OF] = (a[31] != b[31]) && (r[31] != a[31]);
    end else begin
      wide = {1'b0, a} + {1'b0, b} + {32'b0, cin};
      r = wide[31:0];
      f[`X86_EFLAGS_OF] = (a[31] == b[31]) && (r[31] != a[31]);
    end
    // Bit 32 is the carry, or the borrow for subtract
    if (!keep_cf) f[`X86_EFLAGS_CF] = wide[32];
    f[`X86_EFLAGS_AF] = a[4] ^ b[4] ^ r[4];
    f = with_szp(f, r);
  endtask

  task automatic logic_flags(input word_t r, inout eflags_t f);
    f[`X86_EFLAGS_CF] = 1'b0;
    f[`X86_EFLAGS_OF] = 1'b0;
    f[`X86_EFLAGS_AF] = 1'b0;
    f = with_szp(f, r);
  endtask

  task automatic shift_rot(input cmd_e op, input word_t a, input logic [4:0] n,
                           inout eflags_t f, output word_t r);
    int k;
    int i;
    k = n;
    r = a;
    // Count of zero leaves flags alone
    if (k != 0) begin
      case (op)
        cmd_shl: begin
          r = a << k;
          f[`X86_EFLAGS_CF] = a[32 - k];
          f = with_szp(f, r);
        end
        cmd_shr: begin
          r = a >> k;
          f[`X86_EFLAGS_CF] = a[k - 1];
          f = with_szp(f, r);
        end
        cmd_rol: begin
          for (i = 0; i < k; i++) r = {r[30:0], r[31]};
          f[`X86_EFLAGS_CF] = r[0];
        end
        default: begin
          for (i = 0; i < k; i++) r = {r[0], r[31:1]};
          f[`X86_EFLAGS_CF] = r[31];
        end
      endcase
    end
  endtask

  // Expected result of one instruction, then commit to the reference state
  task automatic model_exec(input exec_req_t r, output exec_res_t e);
    eflags_t f;
    word_t   v;
    word_t   cnt;
    logic    zf;
    logic    taken;
    f = m_eflags;
    zf = m_eflags[`X86_EFLAGS_ZF];
    e.opnd0_w = r.opnd0;
    e.opnd1_w = r.opnd1;
    taken = 1'b0;
    case (r.opc)
      cmd_add, cmd_adc, cmd_inc, cmd_sub, cmd_sbb, cmd_dec: begin
        case (r.opc)
          cmd_add: arith(r.opnd0, r.opnd1, 1'b0, 1'b0, 1'b0, f, v);
          cmd_adc: arith(r.opnd0, r.opnd1, m_eflags[`X86_EFLAGS_CF], 1'b0, 1'b0, f, v);
          cmd_inc: arith(r.opnd0, 32'd1, 1'b0, 1'b0, 1'b1, f, v);
          cmd_sub: arith(r.opnd0, r.opnd1, 1'b0, 1'b1, 1'b0, f, v);
          cmd_sbb: arith(r.opnd0, r.opnd1, m_eflags[`X86_EFLAGS_CF], 1'b1, 1'b0, f, v);
          default: arith(r.opnd0, 32'd1, 1'b0, 1'b1, 1'b1, f, v);
        endcase
        e.opnd0_w = v;
      end
      // Flags only
      cmd_cmp: arith(r.opnd0, r.opnd1, 1'b0, 1'b1, 1'b0, f, v);
      cmd_test: logic_flags(r.opnd0 & r.opnd1, f);
      cmd_and, cmd_or, cmd_xor: begin
        if (r.opc == cmd_and) v = r.opnd0 & r.opnd1;
        else if (r.opc == cmd_or) v = r.opnd0 | r.opnd1;
        else v = r.opnd0 ^ r.opnd1;
        logic_flags(v, f);
        e.opnd0_w = v;
      end
      cmd_not: e.opnd0_w = ~r.opnd0;
      cmd_shl, cmd_shr, cmd_rol, cmd_ror: begin
        shift_rot(r.opc, r.opnd0, r.opnd1[4:0], f, v);
        e.opnd0_w = v;
      end
      // ESP adjusts, calls and returns jump to opnd0
      cmd_push: e.opnd1_w = r.opnd1 - r.opnd2;
      cmd_pop: e.opnd1_w = r.opnd1 + r.opnd2;
      cmd_callr, cmd_calli: begin
        e.opnd1_w = r.opnd1 - r.opnd2;
        taken = 1'b1;
      end
      cmd_ret: begin
        e.opnd1_w = r.opnd1 + r.opnd2;
        taken = 1'b1;
      end
      cmd_loop, cmd_loope, cmd_loopne: begin
        cnt = r.opnd1 - r.opnd2;
        e.opnd1_w = cnt;
        if (r.opc == cmd_loop) taken = (cnt != 0);
        else if (r.opc == cmd_loope) taken = (cnt != 0) && zf;
        else taken = (cnt != 0) && !zf;
      end
      cmd_mov, cmd_lea: e.opnd0_w = r.opnd1;
      cmd_movsx: e.opnd0_w = {{24{r.opnd1[7]}}, r.opnd1[7:0]};
      cmd_movzx: e.opnd0_w = {24'h0, r.opnd1[7:0]};
      cmd_xchg: begin
        e.opnd0_w = r.opnd1;
        e.opnd1_w = r.opnd0;
      end
      cmd_stc: f[`X86_EFLAGS_CF] = 1'b1;
      cmd_clc: f[`X86_EFLAGS_CF] = 1'b0;
      cmd_std: f[`X86_EFLAGS_DF] = 1'b1;
      cmd_cld: f[`X86_EFLAGS_DF] = 1'b0;
      // AH gets SF ZF 0 AF 0 PF 1 CF
      cmd_lahf: e.opnd0_w = {r.opnd0[31:16], f[`X86_EFLAGS_SF], f[`X86_EFLAGS_ZF], 1'b0,
                             f[`X86_EFLAGS_AF], 1'b0, f[`X86_EFLAGS_PF], 1'b1,
                             f[`X86_EFLAGS_CF], r.opnd0[7:0]};
      cmd_sahf: begin
        f[`X86_EFLAGS_SF] = r.opnd0[15];
        f[`X86_EFLAGS_ZF] = r.opnd0[14];
        f[`X86_EFLAGS_AF] = r.opnd0[12];
        f[`X86_EFLAGS_PF] = r.opnd0[10];
        f[`X86_EFLAGS_CF] = r.opnd0[8];
      end
      cmd_jmp: taken = 1'b1;
      cmd_jz: taken = zf;
      cmd_jnz: taken = !zf;
      cmd_jecxz: taken = r.ecx_is_zero;
      default: ;
    endcase
    e.eflags = f;
    e.next_eip = taken ? r.opnd0 : m_eip + word_t'(r.instr_len);
    m_eflags = f;
    m_eip = e.next_eip;
  endtask

  // Random command out of a contiguous range of the enum
  function automatic cmd_e pick(input cmd_e first, input cmd_e last);
    return cmd_e'(int'(first) + ($urandom % (int'(last) - int'(first) + 1)));
  endfunction

  function automatic exec_req_t rand_req(input cmd_e opc);
    exec_req_t r;
    r.opc = opc;
    r.opnd0 = $urandom;
    // Equal operands now and then for zero results
    r.opnd1 = ($urandom % 4 == 0) ? r.opnd0 : $urandom;
    r.opnd2 = $urandom;
    r.instr_len = 4'($urandom % 15 + 1);
    r.ecx_is_zero = $urandom % 2;
    return r;
  endfunction

  // Strobe one instruction at a falling edge, check it one cycle later
  task automatic issue(input exec_req_t r, input int gap);
    exec_res_t exp;
    model_exec(r, exp);
    instr_valid = 1'b1;
    req = r;
    @(negedge clk);
    instr_valid = 1'b0;
    check_valid("res_valid after strobe", res_valid, 1'b1);
    check_word("res.opnd0_w", res.opnd0_w, exp.opnd0_w);
    check_word("res.opnd1_w", res.opnd1_w, exp.opnd1_w);
    check_eflags("res.eflags", res.eflags, exp.eflags);
    check_word("res.next_eip", res.next_eip, exp.next_eip);
    check_eflags("eflags", eflags, m_eflags);
    check_word("eip", eip, m_eip);
    repeat (gap) begin
      @(negedge clk);
      check_valid("res_valid in idle cycle", res_valid, 1'b0);
    end
  endtask

  initial begin
    exec_req_t r;
    int        i;
    void'($urandom(23));
    arst_n = 1'b0;
    instr_valid = 1'b0;
    req = '0;
    m_eflags = `X86_RESET_EFLAGS;
    m_eip = `X86_RESET_EIP;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Reset values before the first strobe
    check_valid("res_valid after reset", res_valid, 1'b0);
    check_word("eip after reset", eip, `X86_RESET_EIP);
    check_eflags("eflags after reset", eflags, `X86_RESET_EFLAGS);
    end_test("1 reset");

    for (i = 0; i < N_ALU; i++) begin
      issue(rand_req(pick(cmd_add, cmd_ror)), $urandom % 2);
    end
    end_test("2 alu");

    // CMP in between moves ZF for LOOPE and LOOPNE
    for (i = 0; i < N_ADJ; i++) begin
      if ($urandom % 4 == 0) begin
        r = rand_req(cmd_cmp);
      end else begin
        r = rand_req(pick(cmd_push, cmd_loopne));
        if (r.opc >= cmd_loop) begin
          r.opnd1 = $urandom % 3;
          r.opnd2 = 32'd1;
        end else begin
          r.opnd2 = 32'd4;
        end
      end
      issue(r, $urandom % 2);
    end
    end_test("3 adjust");

    for (i = 0; i < N_MOVE; i++) begin
      issue(rand_req(pick(cmd_mov, cmd_xchg)), $urandom % 2);
    end
    end_test("4 move");

    for (i = 0; i < N_META; i++) begin
      if ($urandom % 3 == 0) r = rand_req(pick(cmd_add, cmd_ror));
      else r = rand_req(pick(cmd_stc, cmd_sahf));
      issue(r, $urandom % 2);
    end
    end_test("5 meta");

    // Back-to-back branches that each see the EIP of the one before
    for (i = 0; i < N_BR; i++) begin
      if ($urandom % 4 == 0) r = rand_req(cmd_cmp);
      else if ($urandom % 5 == 0) r = rand_req(cmd_nop);
      else r = rand_req(pick(cmd_jmp, cmd_jecxz));
      issue(r, 0);
    end
    end_test("6 branch");

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: x86_exec.f
+incdir+include
hw/x86_exec_pkg.sv
hw/alu.sv
hw/meta_unit.sv
hw/cfu.sv
hw/execute.sv
hw/arch_state.sv
hw/x86_exec_top.sv
tests/x86_exec_tb.sv
